/* hw/thor_isa_pkg.sv */
// ====================
// Thor instruction encodings for the reduced front end opcode set
// All formats overlay one 48-bit word through a packed union
// ====================
`default_nettype none

package thor_isa_pkg;

	localparam int insn_bits = 48;
	localparam int opc_bits = 8;
	localparam int reg_bits = 6;
	localparam int fn_bits = 7;

	// ====================
	// Opcodes in [7:0]
	// ====================
	localparam logic [opc_bits-1:0] op_r2    = 8'h02;
	localparam logic [opc_bits-1:0] op_addi  = 8'h04;
	localparam logic [opc_bits-1:0] op_andi  = 8'h08;
	localparam logic [opc_bits-1:0] op_ori   = 8'h09;
	localparam logic [opc_bits-1:0] op_addil = 8'h14;
	localparam logic [opc_bits-1:0] op_jmp   = 8'h20;
	localparam logic [opc_bits-1:0] op_jeq   = 8'h26;
	localparam logic [opc_bits-1:0] op_rts   = 8'h2f;
	// Postfix, only meaningful in the word after an instruction
	localparam logic [opc_bits-1:0] op_exi23 = 8'h51;
	localparam logic [opc_bits-1:0] op_ldb   = 8'h80;
	localparam logic [opc_bits-1:0] op_ldbu  = 8'h81;
	localparam logic [opc_bits-1:0] op_ldw   = 8'h82;
	localparam logic [opc_bits-1:0] op_ldo   = 8'h86;
	localparam logic [opc_bits-1:0] op_stb   = 8'h90;
	localparam logic [opc_bits-1:0] op_sto   = 8'h93;
	localparam logic [opc_bits-1:0] op_nop   = 8'hf1;

	// R2 function codes, held in [47:41]
	localparam logic [fn_bits-1:0] fn_add = 7'h04;
	localparam logic [fn_bits-1:0] fn_mul = 7'h08;

	// ====================
	// Formats, msb first
	// ====================
	typedef struct packed {
		logic [insn_bits-opc_bits-1:0] payload;
		logic [opc_bits-1:0] opcode;
	} any_fmt_t;

	// Short immediate ALU
	typedef struct packed {
		logic [15:0] pad;
		logic [10:0] imm;
		logic [reg_bits-1:0] ra;
		logic [reg_bits-1:0] rt;
		logic vec;
		logic [opc_bits-1:0] opcode;
	} ri_fmt_t;

	// Long immediate ALU
	typedef struct packed {
		logic [3:0] pad;
		logic [22:0] imm;
		logic [reg_bits-1:0] ra;
		logic [reg_bits-1:0] rt;
		logic vec;
		logic [opc_bits-1:0] opcode;
	} ril_fmt_t;

	typedef struct packed {
		logic [fn_bits-1:0] func;
		logic [13:0] pad;
		logic [reg_bits-1:0] rb;
		logic [reg_bits-1:0] ra;
		logic [reg_bits-1:0] rt;
		logic vec;
		logic [opc_bits-1:0] opcode;
	} r2_fmt_t;

	// Loads put Rt in [14:9], stores put Rc there
	typedef struct packed {
		logic [15:0] pad;
		logic [10:0] disp;
		logic [reg_bits-1:0] ra;
		logic [reg_bits-1:0] rc;
		logic vec;
		logic [opc_bits-1:0] opcode;
	} mem_fmt_t;

	typedef struct packed {
		logic [10:0] tgthi;
		logic [9:0] tgtlo;
		logic [reg_bits-1:0] rb;
		logic [reg_bits-1:0] ra;
		logic pad;
		logic [2:0] ca;
		logic [1:0] lk;
		logic vec;
		logic [opc_bits-1:0] opcode;
	} jxx_fmt_t;

	typedef struct packed {
		logic [15:0] pad;
		logic [22:0] payload;
		logic vec;
		logic [opc_bits-1:0] opcode;
	} exi_fmt_t;

	typedef union packed {
		any_fmt_t any;
		ri_fmt_t ri;
		ril_fmt_t ril;
		r2_fmt_t r2;
		mem_fmt_t mem;
		jxx_fmt_t jxx;
		exi_fmt_t exi;
	} instruction_t;

endpackage

`default_nettype wire

/* hw/thor_decode_pkg.sv */
// ====================
// Decoded instruction bundle and bus side constants for the front end
// ====================
`default_nettype none

package thor_decode_pkg;

	localparam int word_bits = 64;
	localparam int adr_bits = 32;
	// First fetch address after reset
	localparam logic [adr_bits-1:0] reset_vector = 32'h0000_0100;

	// Memory access size
	typedef enum logic [1:0] {byt, wyde, tetra, octa} memsz_t;

	// ====================
	// Decode bundle
	// ====================
	typedef struct packed {
		logic rfwr;
		// Code address register write, jumps with a link only
		logic carfwr;
		logic [2:0] cat;
		logic [thor_isa_pkg::reg_bits-1:0] ra;
		logic [thor_isa_pkg::reg_bits-1:0] rb;
		logic [thor_isa_pkg::reg_bits-1:0] rc;
		logic [thor_isa_pkg::reg_bits-1:0] rt;
		logic [word_bits-1:0] imm;
		logic ld;
		logic ldz;
		logic st;
		logic mul;
		logic jmp;
		logic jxx;
		logic rts;
		logic multi_cycle;
		logic is_vector;
		memsz_t memsz;
		// Pc relative, already doubled and sign extended
		logic [word_bits-1:0] tgt_ofs;
	} decode_out_t;

endpackage

`default_nettype wire

/* hw/fetch_if.sv */
// ====================
// Fetched instruction channel, fetch unit to decode stage
// ====================
`timescale 1ns/1ps
`default_nettype none

interface fetch_if;
	logic valid;
	logic ready;
	thor_isa_pkg::instruction_t ir;
	// Postfix word or a NOP
	thor_isa_pkg::instruction_t xir;
	logic [thor_decode_pkg::adr_bits-1:0] pc;

	modport fetch (output valid, output ir, output xir, output pc, input ready);
	modport decode (input valid, input ir, input xir, input pc, output ready);
endinterface

`default_nettype wire

/* hw/thor_fetch.sv */
// ====================
// Sequential instruction fetch over Wishbone classic
// Keeps one lookahead word and folds an EXI23 postfix into its instruction
// ====================
`timescale 1ns/1ps
`default_nettype none

module thor_fetch
(
	input wire clk,
	input wire reset,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output logic [thor_decode_pkg::adr_bits-1:0] wb_adr,
	output logic [thor_decode_pkg::word_bits/8-1:0] wb_sel,
	input wire [thor_decode_pkg::word_bits-1:0] wb_dat_i,
	input wire wb_ack,
	fetch_if.fetch fq
);

	// FSM as two flags: idle, reading first word, reading lookahead word
	logic busy;
	logic lookahead;
	// Address of the next instruction to offer
	logic [thor_decode_pkg::adr_bits-1:0] fpc;
	logic buf_full;
	thor_isa_pkg::instruction_t buf_ir;
	logic offer_valid;
	thor_isa_pkg::instruction_t offer_ir;
	thor_isa_pkg::instruction_t offer_xir;
	logic [thor_decode_pkg::adr_bits-1:0] offer_pc;
	thor_isa_pkg::instruction_t rd_word;
	logic offer_free;
	logic is_postfix;

	assign rd_word = wb_dat_i[thor_isa_pkg::insn_bits-1:0];
	assign is_postfix = rd_word.any.opcode == thor_isa_pkg::op_exi23;
	// Slot is free now or empties on this edge
	assign offer_free = !offer_valid || fq.ready;

	// Read only master, whole word lanes
	assign wb_cyc = busy;
	assign wb_stb = busy;
	assign wb_we = 1'b0;
	assign wb_sel = '1;
	assign wb_adr = lookahead ? fpc + 32'd8 : fpc;

	assign fq.valid = offer_valid;
	assign fq.ir = offer_ir;
	assign fq.xir = offer_xir;
	assign fq.pc = offer_pc;

	// ====================
	// Control
	// ====================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			lookahead <= 1'b0;
			buf_full <= 1'b0;
			offer_valid <= 1'b0;
			fpc <= thor_decode_pkg::reset_vector;
		end
		else
		begin
			if (offer_valid && fq.ready)
				offer_valid <= 1'b0;
			if (!busy)
			begin
				// Refill the buffer first
				if (!buf_full)
				begin
					busy <= 1'b1;
					lookahead <= 1'b0;
				end
				// Read ahead only when the result has a slot to go to
				else if (offer_free)
				begin
					busy <= 1'b1;
					lookahead <= 1'b1;
				end
			end
			else if (wb_ack)
			begin
				busy <= 1'b0;
				if (!lookahead)
					buf_full <= 1'b1;
				else
				begin
					offer_valid <= 1'b1;
					// Postfix consumed, buffer must be refilled
					if (is_postfix)
					begin
						buf_full <= 1'b0;
						fpc <= fpc + 32'd16;
					end
					else
						fpc <= fpc + 32'd8;
				end
			end
		end
	end

	// ====================
	// Payload
	// ====================
	always_ff @(posedge clk)
	begin
		if (busy && wb_ack)
		begin
			if (!lookahead)
				buf_ir <= rd_word;
			else
			begin
				offer_ir <= buf_ir;
				offer_pc <= fpc;
				if (is_postfix)
					offer_xir <= rd_word;
				else
				begin
					offer_xir <= 48'(thor_isa_pkg::op_nop);
					// Lookahead word becomes the next ir
					buf_ir <= rd_word;
				end
			end
		end
	end

	// Request address holds until acknowledged
	assert property (@(posedge clk) disable iff (reset)
		wb_stb && !wb_ack |=> $stable(wb_adr));

	// Stalled offer neither drops nor changes
	assert property (@(posedge clk) disable iff (reset)
		offer_valid && !fq.ready |=> offer_valid && $stable(offer_ir)
			&& $stable(offer_xir) && $stable(offer_pc));

endmodule

`default_nettype wire

/* hw/thor_decoder.sv */
// ====================
// Combinational decode of one instruction plus its optional postfix word
// ====================
`timescale 1ns/1ps
`default_nettype none

module thor_decoder
(
	input wire thor_isa_pkg::instruction_t ir,
	input wire thor_isa_pkg::instruction_t xir,
	output thor_decode_pkg::decode_out_t deco
);

	always_comb
	begin
		// Fixed source positions
		deco.ra = ir.ri.ra;
		deco.rb = ir.r2.rb;
		deco.is_vector = ir.ri.vec;

		// Target register, jumps link into lk
		case (ir.any.opcode)
			thor_isa_pkg::op_jmp, thor_isa_pkg::op_jeq:
				deco.rt = {4'd0, ir.jxx.lk};
			default:
				deco.rt = ir.ri.rt;
		endcase

		// Stores carry the data register in the Rt slot
		case (ir.any.opcode)
			thor_isa_pkg::op_stb, thor_isa_pkg::op_sto:
				deco.rc = ir.mem.rc;
			default:
				deco.rc = ir[34:29];
		endcase

		// Link to a code address register
		case (ir.any.opcode)
			thor_isa_pkg::op_jmp, thor_isa_pkg::op_jeq:
				deco.carfwr = ir.jxx.lk != 2'd0;
			default:
				deco.carfwr = 1'b0;
		endcase
		case (ir.any.opcode)
			thor_isa_pkg::op_jmp, thor_isa_pkg::op_jeq:
				deco.cat = {1'b0, ir.jxx.lk};
			default:
				deco.cat = 3'd0;
		endcase

		// Register file update
		case (ir.any.opcode)
			thor_isa_pkg::op_r2, thor_isa_pkg::op_addi, thor_isa_pkg::op_andi,
			thor_isa_pkg::op_ori, thor_isa_pkg::op_addil:
				deco.rfwr = 1'b1;
			default:
				deco.rfwr = 1'b0;
		endcase

		// ====================
		// Immediate
		// ====================
		case (ir.any.opcode)
			thor_isa_pkg::op_addi:
				deco.imm = {{53{ir.ri.imm[10]}}, ir.ri.imm};
			// Ones above keep the upper bits on AND
			thor_isa_pkg::op_andi:
				deco.imm = {{53{1'b1}}, ir.ri.imm};
			thor_isa_pkg::op_ori:
				deco.imm = {{53{1'b0}}, ir.ri.imm};
			thor_isa_pkg::op_addil:
				deco.imm = {{41{ir.ril.imm[22]}}, ir.ril.imm};
			// Memory displacement
			thor_isa_pkg::op_ldb, thor_isa_pkg::op_ldbu, thor_isa_pkg::op_ldw,
			thor_isa_pkg::op_ldo, thor_isa_pkg::op_stb, thor_isa_pkg::op_sto:
				deco.imm = {{53{ir.mem.disp[10]}}, ir.mem.disp};
			default:
				deco.imm = 64'd0;
		endcase
		// Postfix supplies the upper bits above the long immediate
		if (xir.any.opcode == thor_isa_pkg::op_exi23)
			deco.imm = {{18{xir.exi.payload[22]}}, xir.exi.payload, ir.ril.imm};

		case (ir.any.opcode)
			thor_isa_pkg::op_ldb, thor_isa_pkg::op_ldbu,
			thor_isa_pkg::op_ldw, thor_isa_pkg::op_ldo:
				deco.ld = 1'b1;
			default:
				deco.ld = 1'b0;
		endcase
		deco.ldz = ir.any.opcode == thor_isa_pkg::op_ldbu;
		case (ir.any.opcode)
			thor_isa_pkg::op_stb, thor_isa_pkg::op_sto:
				deco.st = 1'b1;
			default:
				deco.st = 1'b0;
		endcase

		case (ir.any.opcode)
			thor_isa_pkg::op_ldb, thor_isa_pkg::op_ldbu, thor_isa_pkg::op_stb:
				deco.memsz = thor_decode_pkg::byt;
			thor_isa_pkg::op_ldw:
				deco.memsz = thor_decode_pkg::wyde;
			default:
				deco.memsz = thor_decode_pkg::octa;
		endcase

		case (ir.any.opcode)
			thor_isa_pkg::op_r2:
				case (ir.r2.func)
					thor_isa_pkg::fn_mul:
						deco.mul = 1'b1;
					default:
						deco.mul = 1'b0;
				endcase
			default:
				deco.mul = 1'b0;
		endcase

		deco.jmp = ir.any.opcode == thor_isa_pkg::op_jmp;
		deco.jxx = ir.any.opcode == thor_isa_pkg::op_jeq;
		deco.rts = ir.any.opcode == thor_isa_pkg::op_rts;

		// Ops that tie up the downstream unit for several cycles
		case (ir.any.opcode)
			thor_isa_pkg::op_r2:
				case (ir.r2.func)
					thor_isa_pkg::fn_mul:
						deco.multi_cycle = 1'b1;
					default:
						deco.multi_cycle = 1'b0;
				endcase
			thor_isa_pkg::op_ldb, thor_isa_pkg::op_ldbu, thor_isa_pkg::op_ldw,
			thor_isa_pkg::op_ldo, thor_isa_pkg::op_stb, thor_isa_pkg::op_sto,
			thor_isa_pkg::op_jmp, thor_isa_pkg::op_jeq, thor_isa_pkg::op_rts:
				deco.multi_cycle = 1'b1;
			default:
				deco.multi_cycle = 1'b0;
		endcase

		// Halfword granular target offset
		deco.tgt_ofs = {{42{ir.jxx.tgthi[10]}}, ir.jxx.tgthi, ir.jxx.tgtlo, 1'b0};
	end

endmodule

`default_nettype wire

/* hw/thor_decode_stage.sv */
// ====================
// One slot decode register behind the fetch channel
// Also forms the jump target for jumps
// ====================
`timescale 1ns/1ps
`default_nettype none

module thor_decode_stage
(
	input wire clk,
	input wire reset,
	input wire dec_ready,
	fetch_if.decode fq,
	output logic dec_valid,
	output logic [thor_decode_pkg::adr_bits-1:0] dec_pc,
	output thor_decode_pkg::decode_out_t deco,
	output logic [thor_decode_pkg::word_bits-1:0] jump_target
);

	thor_decode_pkg::decode_out_t dec_comb;
	logic take;

	thor_decoder i_decoder
	(
		.ir(fq.ir),
		.xir(fq.xir),
		.deco(dec_comb)
	);

	// Accept when the slot is empty or draining
	assign fq.ready = !dec_valid || dec_ready;
	assign take = fq.valid && fq.ready;

	always_ff @(posedge clk)
	begin
		if (reset)
			dec_valid <= 1'b0;
		else if (take)
			dec_valid <= 1'b1;
		else if (dec_ready)
			dec_valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (take)
		begin
			deco <= dec_comb;
			dec_pc <= fq.pc;
			// Target only for jumps, zero otherwise
			if (dec_comb.jmp || dec_comb.jxx)
				jump_target <= {{(thor_decode_pkg::word_bits-thor_decode_pkg::adr_bits){1'b0}},
					fq.pc} + dec_comb.tgt_ofs;
			else
				jump_target <= '0;
		end
	end

	// Held slot is not overwritten by a new transfer
	assert property (@(posedge clk) disable iff (reset)
		dec_valid && !dec_ready |=> dec_valid && $stable(dec_pc) && $stable(deco)
			&& $stable(jump_target));

endmodule

`default_nettype wire

/* hw/thor_frontend.sv */
// ====================
// Front end top, Wishbone fetch feeding the decode register
// ====================
`timescale 1ns/1ps
`default_nettype none

module thor_frontend
(
	input wire clk,
	input wire reset,
	// Wishbone classic master
	output wire wb_cyc,
	output wire wb_stb,
	output wire wb_we,
	output wire [31:0] wb_adr,
	output wire [7:0] wb_sel,
	input wire [63:0] wb_dat_i,
	input wire wb_ack,
	// Decoded instruction
	output wire dec_valid,
	input wire dec_ready,
	output wire [31:0] dec_pc,
	output wire rfwr,
	output wire carfwr,
	output wire [2:0] cat,
	output wire [5:0] ra,
	output wire [5:0] rb,
	output wire [5:0] rc,
	output wire [5:0] rt,
	output wire [63:0] imm,
	output wire ld,
	output wire ldz,
	output wire st,
	output wire mul,
	output wire jmp,
	output wire jxx,
	output wire rts,
	output wire multi_cycle,
	output wire is_vector,
	output wire [1:0] memsz,
	output wire [63:0] tgt_ofs,
	output wire [63:0] jump_target
);

	thor_decode_pkg::decode_out_t deco;

	fetch_if i_fq ();

	thor_fetch i_fetch
	(
		.clk(clk),
		.reset(reset),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_sel(wb_sel),
		.wb_dat_i(wb_dat_i),
		.wb_ack(wb_ack),
		.fq(i_fq)
	);

	thor_decode_stage i_decode
	(
		.clk(clk),
		.reset(reset),
		.dec_ready(dec_ready),
		.fq(i_fq),
		.dec_valid(dec_valid),
		.dec_pc(dec_pc),
		.deco(deco),
		.jump_target(jump_target)
	);

	// Unpack in bundle field order
	assign {rfwr, carfwr, cat, ra, rb, rc, rt, imm, ld, ldz, st, mul, jmp, jxx, rts,
		multi_cycle, is_vector, memsz, tgt_ofs} = deco;

endmodule

`default_nettype wire

/* tb/tb_wb_mem.sv */
// ====================
// Wishbone classic read memory for the front end testbench
// Acks each read after 0 to 3 LFSR chosen wait states
// ====================
`timescale 1ns/1ps
`default_nettype none

module tb_wb_mem
(
	input wire clk,
	input wire reset,
	input wire cyc,
	input wire stb,
	input wire [31:0] adr,
	output logic [63:0] dat_o,
	output logic ack
);

	// 2 KB of 64-bit words, loaded by the testbench
	logic [63:0] mem [0:255];
	// Wait state source
	logic [31:0] lfsr = 32'hf89e;
	logic pending = 1'b0;
	logic [1:0] wait_left = 2'd0;

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	initial
	begin
		ack = 1'b0;
		dat_o = '0;
	end

	always @(posedge clk)
	begin : serve
		logic [1:0] draw;
		ack <= 1'b0;
		if (reset)
			pending <= 1'b0;
		// A new or waiting request, never the cycle of its own ack
		else if (cyc && stb && !ack)
		begin
			if (!pending)
			begin
				// One LFSR step per wait count bit
				lfsr = lfsr_next(lfsr);
				draw[0] = lfsr[0];
				lfsr = lfsr_next(lfsr);
				draw[1] = lfsr[0];
				if (draw == 2'd0)
				begin
					ack <= 1'b1;
					dat_o <= mem[adr[10:3]];
				end
				else
				begin
					pending <= 1'b1;
					wait_left <= draw - 2'd1;
				end
			end
			else if (wait_left == 2'd0)
			begin
				ack <= 1'b1;
				dat_o <= mem[adr[10:3]];
				pending <= 1'b0;
			end
			else
				wait_left <= wait_left - 2'd1;
		end
	end

endmodule

`default_nettype wire

/* tb/tb_frontend.sv */
// ====================
// Directed tests for the Thor front end, fetch through decode register
// ====================
`timescale 1ns/1ps
`default_nettype none

module tb_frontend;

	// Cycles allowed for any single wait
	localparam int wait_limit = 200;
	localparam logic [31:0] base = thor_decode_pkg::reset_vector;

	logic clk;
	logic reset;
	logic dec_ready;
	wire wb_cyc;
	wire wb_stb;
	wire wb_we;
	wire [31:0] wb_adr;
	wire [7:0] wb_sel;
	wire [63:0] wb_dat_i;
	wire wb_ack;
	wire dec_valid;
	wire [31:0] dec_pc;
	wire rfwr;
	wire carfwr;
	wire [2:0] cat;
	wire [5:0] ra;
	wire [5:0] rb;
	wire [5:0] rc;
	wire [5:0] rt;
	wire [63:0] imm;
	wire ld;
	wire ldz;
	wire st;
	wire mul;
	wire jmp;
	wire jxx;
	wire rts;
	wire multi_cycle;
	wire is_vector;
	wire [1:0] memsz;
	wire [63:0] tgt_ofs;
	wire [63:0] jump_target;
	// Back-pressure stretch source
	logic [31:0] rng;

	thor_frontend i_dut (.*);

	tb_wb_mem i_mem
	(
		.clk(clk),
		.reset(reset),
		.cyc(wb_cyc),
		.stb(wb_stb),
		.adr(wb_adr),
		.dat_o(wb_dat_i),
		.ack(wb_ack)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	// ====================
	// Helpers
	// ====================
	task automatic stop_on_error(input string line);
		$display("%s", line);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected)
			stop_on_error($sformatf("FAILED %s expected %h actual %h", name, expected,
				actual));
	endtask

	// Read only master, full lanes, word aligned addresses
	always @(negedge clk)
	begin
		if (!reset && wb_cyc)
		begin
			check_value("bus stb", 64'd1, 64'(wb_stb));
			check_value("bus we", 64'd0, 64'(wb_we));
			check_value("bus sel", 64'hff, 64'(wb_sel));
			check_value("bus adr align", 64'd0, 64'(wb_adr[2:0]));
		end
	end

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output int unsigned v);
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			rng = lfsr_next(rng);
			v = {v[30:0], rng[0]};
		end
	endtask

	// NOP everywhere, address kept in the upper bits
	task automatic clear_mem();
		for (int i = 0; i < 256; i++)
			i_mem.mem[i] = {32'(i), 24'd0, thor_isa_pkg::op_nop};
	endtask

	task automatic put_word(input logic [31:0] pc, input logic [47:0] insn);
		i_mem.mem[pc[10:3]] = {16'd0, insn};
	endtask

	// Instruction formats by ISA field position
	function automatic logic [47:0] ri_word(input logic [7:0] op, input logic [5:0] t,
		input logic [5:0] a, input logic [10:0] i11);
		return {16'd0, i11, a, t, 1'b0, op};
	endfunction

	function automatic logic [47:0] ril_word(input logic [7:0] op, input logic [5:0] t,
		input logic [5:0] a, input logic [22:0] i23);
		return {4'd0, i23, a, t, 1'b0, op};
	endfunction

	function automatic logic [47:0] r2_word(input logic [5:0] t, input logic [5:0] a,
		input logic [5:0] b, input logic [6:0] fn);
		return {fn, 14'd0, b, a, t, 1'b0, thor_isa_pkg::op_r2};
	endfunction

	function automatic logic [47:0] jxx_word(input logic [7:0] op, input logic [1:0] lk,
		input logic [5:0] a, input logic [5:0] b, input logic [20:0] tgt);
		return {tgt[20:10], tgt[9:0], b, a, 1'b0, 3'd0, lk, 1'b0, op};
	endfunction

	function automatic logic [47:0] exi_word(input logic [22:0] payload);
		return {16'd0, payload, 1'b0, thor_isa_pkg::op_exi23};
	endfunction

	task automatic restart_dut();
		@(posedge clk);
		reset <= 1'b1;
		dec_ready <= 1'b1;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		// Nothing offered or requested straight out of reset
		@(negedge clk);
		check_value("reset dec_valid", 64'd0, 64'(dec_valid));
		check_value("reset wb_cyc", 64'd0, 64'(wb_cyc));
	endtask

	// Returns at a falling edge with dec_valid high
	task automatic wait_item(input string name);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!dec_valid)
		begin
			cycles++;
			if (cycles > wait_limit)
				stop_on_error($sformatf("Timeout, no decoded instruction arrived in %s", name));
			@(negedge clk);
		end
	endtask

	// Transfer edge, dec_ready is already high
	task automatic accept_item();
		@(posedge clk);
	endtask

	// ====================
	// Tests
	// ====================
	task automatic alu_immediates();
		clear_mem();
		put_word(base, ri_word(thor_isa_pkg::op_addi, 6'd1, 6'd2, 11'h7fb));
		put_word(base + 32'd8, ri_word(thor_isa_pkg::op_andi, 6'd3, 6'd4, 11'h0f0));
		// Vector form, bit 8 set
		put_word(base + 32'd16, ri_word(thor_isa_pkg::op_ori, 6'd5, 6'd6, 11'h4a5) | 48'h100);
		restart_dut();
		wait_item("alu addi");
		check_value("alu addi pc", 64'(base), 64'(dec_pc));
		check_value("alu addi rfwr", 64'd1, 64'(rfwr));
		check_value("alu addi ra", 64'd2, 64'(ra));
		check_value("alu addi is_vector", 64'd0, 64'(is_vector));
		// Minus five
		check_value("alu addi imm", 64'hffff_ffff_ffff_fffb, imm);
		accept_item();
		wait_item("alu andi");
		check_value("alu andi pc", 64'(base + 32'd8), 64'(dec_pc));
		check_value("alu andi rfwr", 64'd1, 64'(rfwr));
		check_value("alu andi imm", {{53{1'b1}}, 11'h0f0}, imm);
		accept_item();
		wait_item("alu ori");
		check_value("alu ori pc", 64'(base + 32'd16), 64'(dec_pc));
		check_value("alu ori rfwr", 64'd1, 64'(rfwr));
		check_value("alu ori is_vector", 64'd1, 64'(is_vector));
		check_value("alu ori imm", 64'h0000_0000_0000_04a5, imm);
		accept_item();
	endtask

	task automatic postfix_merge();
		clear_mem();
		put_word(base, ril_word(thor_isa_pkg::op_addil, 6'd7, 6'd8, 23'h12_3456));
		// Negative postfix so the sign fill shows
		put_word(base + 32'd8, exi_word(23'h40_0001));
		restart_dut();
		wait_item("postfix addil");
		check_value("postfix pc", 64'(base), 64'(dec_pc));
		check_value("postfix imm", {{18{1'b1}}, 23'h40_0001, 23'h12_3456}, imm);
		check_value("postfix rfwr", 64'd1, 64'(rfwr));
		accept_item();
		wait_item("postfix next");
		check_value("postfix next pc", 64'(base + 32'd16), 64'(dec_pc));
		accept_item();
	endtask

	task automatic check_mem_item(input string name, input logic [31:0] pc,
		input logic e_ld, input logic e_ldz, input logic e_st, input logic [1:0] e_sz,
		input logic [5:0] e_rc);
		wait_item(name);
		check_value({name, " pc"}, 64'(pc), 64'(dec_pc));
		check_value({name, " ld"}, 64'(e_ld), 64'(ld));
		check_value({name, " ldz"}, 64'(e_ldz), 64'(ldz));
		check_value({name, " st"}, 64'(e_st), 64'(st));
		check_value({name, " memsz"}, 64'(e_sz), 64'(memsz));
		check_value({name, " multi_cycle"}, 64'd1, 64'(multi_cycle));
		// Data register only matters for stores
		if (e_st)
			check_value({name, " rc"}, 64'(e_rc), 64'(rc));
		accept_item();
	endtask

	task automatic memory_ops();
		clear_mem();
		put_word(base, ri_word(thor_isa_pkg::op_ldb, 6'd10, 6'd4, 11'h010));
		put_word(base + 32'd8, ri_word(thor_isa_pkg::op_ldbu, 6'd11, 6'd4, 11'h011));
		put_word(base + 32'd16, ri_word(thor_isa_pkg::op_ldw, 6'd12, 6'd4, 11'h012));
		put_word(base + 32'd24, ri_word(thor_isa_pkg::op_ldo, 6'd13, 6'd4, 11'h7f8));
		put_word(base + 32'd32, ri_word(thor_isa_pkg::op_stb, 6'd7, 6'd4, 11'h020));
		put_word(base + 32'd40, ri_word(thor_isa_pkg::op_sto, 6'd9, 6'd4, 11'h028));
		restart_dut();
		check_mem_item("mem ldb", base, 1'b1, 1'b0, 1'b0, thor_decode_pkg::byt, 6'd0);
		check_mem_item("mem ldbu", base + 32'd8, 1'b1, 1'b1, 1'b0, thor_decode_pkg::byt, 6'd0);
		check_mem_item("mem ldw", base + 32'd16, 1'b1, 1'b0, 1'b0, thor_decode_pkg::wyde, 6'd0);
		check_mem_item("mem ldo", base + 32'd24, 1'b1, 1'b0, 1'b0, thor_decode_pkg::octa, 6'd0);
		check_mem_item("mem stb", base + 32'd32, 1'b0, 1'b0, 1'b1, thor_decode_pkg::byt, 6'd7);
		check_mem_item("mem sto", base + 32'd40, 1'b0, 1'b0, 1'b1, thor_decode_pkg::octa, 6'd9);
	endtask

	task automatic jumps_and_rts();
		clear_mem();
		// Backward jump with link register 2
		put_word(base, jxx_word(thor_isa_pkg::op_jmp, 2'd2, 6'd1, 6'd2, 21'h1f_fff0));
		put_word(base + 32'd8, jxx_word(thor_isa_pkg::op_jeq, 2'd0, 6'd3, 6'd4, 21'h00_0123));
		put_word(base + 32'd16, {40'd0, thor_isa_pkg::op_rts});
		restart_dut();
		wait_item("jmp");
		check_value("jmp jmp", 64'd1, 64'(jmp));
		check_value("jmp jxx", 64'd0, 64'(jxx));
		check_value("jmp carfwr", 64'd1, 64'(carfwr));
		check_value("jmp cat", 64'd2, 64'(cat));
		check_value("jmp rt", 64'd2, 64'(rt));
		check_value("jmp multi_cycle", 64'd1, 64'(multi_cycle));
		// Minus 16 halfwords is minus 32 bytes
		check_value("jmp tgt_ofs", 64'hffff_ffff_ffff_ffe0, tgt_ofs);
		check_value("jmp target", 64'(base) - 64'd32, jump_target);
		accept_item();
		wait_item("jeq");
		check_value("jeq jmp", 64'd0, 64'(jmp));
		check_value("jeq jxx", 64'd1, 64'(jxx));
		check_value("jeq carfwr", 64'd0, 64'(carfwr));
		check_value("jeq cat", 64'd0, 64'(cat));
		// 0x123 halfwords
		check_value("jeq tgt_ofs", 64'h0000_0000_0000_0246, tgt_ofs);
		check_value("jeq target", 64'(base) + 64'd8 + 64'h246, jump_target);
		accept_item();
		wait_item("rts");
		check_value("rts rts", 64'd1, 64'(rts));
		check_value("rts jmp", 64'd0, 64'(jmp));
		check_value("rts jxx", 64'd0, 64'(jxx));
		check_value("rts target", 64'd0, jump_target);
		accept_item();
	endtask

	task automatic r2_functions();
		clear_mem();
		put_word(base, r2_word(6'd1, 6'd2, 6'd3, thor_isa_pkg::fn_mul));
		put_word(base + 32'd8, r2_word(6'd4, 6'd5, 6'd6, thor_isa_pkg::fn_add));
		restart_dut();
		wait_item("r2 mul");
		check_value("r2 mul mul", 64'd1, 64'(mul));
		check_value("r2 mul multi_cycle", 64'd1, 64'(multi_cycle));
		check_value("r2 mul rfwr", 64'd1, 64'(rfwr));
		check_value("r2 mul rb", 64'd3, 64'(rb));
		accept_item();
		wait_item("r2 add");
		check_value("r2 add mul", 64'd0, 64'(mul));
		check_value("r2 add multi_cycle", 64'd0, 64'(multi_cycle));
		check_value("r2 add rfwr", 64'd1, 64'(rfwr));
		check_value("r2 add ra", 64'd5, 64'(ra));
		accept_item();
	endtask

	task automatic back_pressure();
		int unsigned stall;
		logic [31:0] held_pc;
		logic [63:0] held_imm;
		logic [31:0] expect_pc;
		clear_mem();
		for (int i = 0; i < 6; i++)
			put_word(base + 32'(8 * i), ri_word(thor_isa_pkg::op_addi, 6'd1, 6'd2, 11'(i + 1)));
		restart_dut();
		@(posedge clk);
		dec_ready <= 1'b0;
		expect_pc = base;
		// Sequential pcs, NOP fill past the program
		for (int k = 0; k < 12; k++)
		begin
			take_bits(3, stall);
			wait_item("backpressure");
			held_pc = dec_pc;
			held_imm = imm;
			check_value("backpressure pc", 64'(expect_pc), 64'(dec_pc));
			repeat (stall)
			begin
				@(negedge clk);
				check_value("backpressure valid held", 64'd1, 64'(dec_valid));
				check_value("backpressure pc held", 64'(held_pc), 64'(dec_pc));
				check_value("backpressure imm held", held_imm, imm);
			end
			// Ready for exactly one edge
			@(posedge clk);
			dec_ready <= 1'b1;
			@(posedge clk);
			dec_ready <= 1'b0;
			expect_pc = expect_pc + 32'd8;
		end
	endtask

	// ====================
	// Sequence
	// ====================
	initial
	begin
		reset = 1'b1;
		dec_ready = 1'b0;
		rng = 32'hf89e;
		alu_immediates();
		postfix_merge();
		memory_ops();
		jumps_and_rts();
		r2_functions();
		back_pressure();
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
hw/thor_isa_pkg.sv
hw/thor_decode_pkg.sv
hw/fetch_if.sv
hw/thor_fetch.sv
hw/thor_decoder.sv
hw/thor_decode_stage.sv
hw/thor_frontend.sv
tb/tb_wb_mem.sv
tb/tb_frontend.sv
